/* files.f */
design/pkt_filter_pkg.sv
design/pkt_length_check.sv
design/drop_packet_fifo.sv
design/stream_out_reg.sv
design/pkt_filter_regs.sv
design/pkt_filter_top.sv
test/pkt_filter_sva.sv
test/pkt_filter_tb.sv

/* test/pkt_filter_tb.sv */
// Packet filter testbench

`timescale 1ns/1ps

module pkt_filter_tb;

  localparam int DATA_W     = 32;
  localparam int FIFO_DEPTH = 64;
  localparam int TOTAL_PKTS = 600;
  // 40 beats of 8 ns per packet plus margin
  localparam int RUN_LIMIT_NS = TOTAL_PKTS * 40 * 8 + 20000;

  logic              clk;
  logic              i_rst_n;
  logic [DATA_W-1:0] i_tdata;
  logic              i_tvalid;
  logic              i_tlast;
  logic              i_terror;
  logic              o_tready;
  logic [DATA_W-1:0] o_tdata;
  logic              o_tvalid;
  logic              o_tlast;
  logic              i_tready;
  logic              i_psel;
  logic              i_penable;
  logic              i_pwrite;
  logic [7:0]        i_paddr;
  logic [31:0]       i_pwdata;
  logic [31:0]       o_prdata;

  // Expected output words, last above data
  logic [DATA_W:0] exp_q[$];
  int              good_cnt;
  int              drop_cnt;
  int              min_len;
  int              max_len;
  int              ready_pct;

  pkt_filter_top #(
    .DATA_W     (DATA_W),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) pkt_filter_top_i (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_tdata   (i_tdata),
    .i_tvalid  (i_tvalid),
    .i_tlast   (i_tlast),
    .i_terror  (i_terror),
    .o_tready  (o_tready),
    .o_tdata   (o_tdata),
    .o_tvalid  (o_tvalid),
    .o_tlast   (o_tlast),
    .i_tready  (i_tready),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .i_pwrite  (i_pwrite),
    .i_paddr   (i_paddr),
    .i_pwdata  (i_pwdata),
    .o_prdata  (o_prdata)
  );

  always #4 clk = ~clk;

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_beat(input logic [DATA_W-1:0] exp_data, input logic exp_last,
                            input logic [DATA_W-1:0] got_data, input logic got_last);
    if (got_data !== exp_data) begin
      report_fail($sformatf("Mismatch at %0t: o_tdata expected %h got %h",
                            $time, exp_data, got_data));
    end
    if (got_last !== exp_last) begin
      report_fail($sformatf("Mismatch at %0t: o_tlast expected %b got %b",
                            $time, exp_last, got_last));
    end
  endtask

  task automatic check_reg(input string name, input logic [31:0] exp_val,
                           input logic [31:0] got_val);
    if (got_val !== exp_val) begin
      report_fail($sformatf("Mismatch at %0t: %s expected %h got %h",
                            $time, name, exp_val, got_val));
    end
  endtask

  task automatic apb_write(input pkt_filter_pkg::reg_addr_e addr, input logic [31:0] data);
    @(negedge clk);
    i_psel    = 1'b1;
    i_pwrite  = 1'b1;
    i_paddr   = addr;
    i_pwdata  = data;
    @(negedge clk);
    i_penable = 1'b1;
    @(negedge clk);
    i_psel    = 1'b0;
    i_penable = 1'b0;
    i_pwrite  = 1'b0;
  endtask

  // Read data is stable from the setup phase on
  task automatic verify_reg(input pkt_filter_pkg::reg_addr_e addr, input logic [31:0] exp_val);
    logic [31:0] got;
    @(negedge clk);
    i_psel    = 1'b1;
    i_pwrite  = 1'b0;
    i_paddr   = addr;
    @(negedge clk);
    i_penable = 1'b1;
    got       = o_prdata;
    @(negedge clk);
    i_psel    = 1'b0;
    i_penable = 1'b0;
    check_reg(addr.name(), exp_val, got);
  endtask

  // Reference drop rule
  function automatic bit pkt_kept(input int len, input bit err);
    return !err && (len >= min_len) && (len <= max_len);
  endfunction

  task automatic send_pkt(input int len, input bit err);
    logic [DATA_W-1:0] data;
    bit                accepted;
    bit                keep;
    keep = pkt_kept(len, err);
    if (keep) begin
      good_cnt++;
    end else begin
      drop_cnt++;
    end
    for (int b = 1; b <= len; b++) begin
      data = $urandom;
      if (keep) begin
        exp_q.push_back({b == len, data});
      end
      i_tvalid = 1'b1;
      i_tdata  = data;
      i_tlast  = (b == len);
      i_terror = err;
      accepted = 1'b0;
      while (!accepted) begin
        accepted = o_tready;
        @(negedge clk);
      end
      // Occasional idle cycle inside the packet
      if ($urandom_range(7) == 0) begin
        i_tvalid = 1'b0;
        @(negedge clk);
      end
    end
    i_tvalid = 1'b0;
    i_tlast  = 1'b0;
    i_terror = 1'b0;
  endtask

  task automatic run_traffic(input int n_pkts);
    for (int p = 0; p < n_pkts; p++) begin
      send_pkt($urandom_range(20, 1), $urandom_range(3) == 0);
      repeat ($urandom_range(2)) @(negedge clk);
    end
  endtask

  task automatic drain_and_count();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
    verify_reg(pkt_filter_pkg::GOOD_CNT, good_cnt);
    verify_reg(pkt_filter_pkg::DROP_CNT, drop_cnt);
  endtask

  // Output side: random ready and compare of every accepted beat
  initial begin
    logic [DATA_W:0] exp_word;
    bit              rdy;
    forever begin
      @(negedge clk);
      rdy      = ($urandom_range(99) < ready_pct);
      i_tready = rdy;
      if (i_rst_n && o_tvalid && rdy) begin
        if (exp_q.size() == 0) begin
          report_fail($sformatf("Unexpected output beat %h at %0t", o_tdata, $time));
        end else begin
          exp_word = exp_q.pop_front();
          check_beat(exp_word[DATA_W-1:0], exp_word[DATA_W], o_tdata, o_tlast);
        end
      end
    end
  end

  initial begin
    #(RUN_LIMIT_NS);
    report_fail("Timeout, traffic did not finish within the run limit");
  end

  initial begin
    wait (pkt_filter_top_i.pkt_filter_sva_i.fail_cnt != 0);
    report_fail("A stream assertion failed, see the error above");
  end

  initial begin
    void'($urandom(32'hbbe4_4495));
    clk       = 1'b0;
    i_rst_n   = 1'b0;
    i_tdata   = '0;
    i_tvalid  = 1'b0;
    i_tlast   = 1'b0;
    i_terror  = 1'b0;
    i_tready  = 1'b1;
    i_psel    = 1'b0;
    i_penable = 1'b0;
    i_pwrite  = 1'b0;
    i_paddr   = '0;
    i_pwdata  = '0;
    good_cnt  = 0;
    drop_cnt  = 0;
    min_len   = 1;
    max_len   = 16'hFFFF;
    ready_pct = 100;
    repeat (3) @(posedge clk);
    @(negedge clk);
    i_rst_n = 1'b1;

    // Reset values
    if (o_tvalid !== 1'b0) begin
      report_fail("o_tvalid is not low after reset");
    end
    if (o_tready !== 1'b1) begin
      report_fail("o_tready is not high after reset");
    end
    verify_reg(pkt_filter_pkg::MIN_LEN, 32'd1);
    verify_reg(pkt_filter_pkg::MAX_LEN, 32'h0000_FFFF);
    verify_reg(pkt_filter_pkg::GOOD_CNT, 32'd0);
    verify_reg(pkt_filter_pkg::DROP_CNT, 32'd0);

    // Default limits, only flagged packets drop
    run_traffic(200);
    drain_and_count();

    // Tight limits
    apb_write(pkt_filter_pkg::MIN_LEN, 32'd4);
    min_len = 4;
    apb_write(pkt_filter_pkg::MAX_LEN, 32'd12);
    max_len = 12;
    verify_reg(pkt_filter_pkg::MIN_LEN, 32'd4);
    verify_reg(pkt_filter_pkg::MAX_LEN, 32'd12);
    run_traffic(150);
    drain_and_count();

    // Output back-pressure
    ready_pct = 50;
    run_traffic(150);
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    ready_pct = 100;
    drain_and_count();

    // Counter clear, then more traffic
    apb_write(pkt_filter_pkg::CTRL, 32'd1);
    good_cnt = 0;
    drop_cnt = 0;
    verify_reg(pkt_filter_pkg::GOOD_CNT, 32'd0);
    verify_reg(pkt_filter_pkg::DROP_CNT, 32'd0);
    run_traffic(100);
    drain_and_count();

    $display("NO ERRORS");
    $finish;
  end

endmodule

/* test/pkt_filter_sva.sv */
// Packet filter stream assertions

`timescale 1ns/1ps

module pkt_filter_sva #(
  parameter int DATA_W     = 32,
  parameter int FIFO_DEPTH = 64
) (
  input logic              clk,
  input logic              i_rst_n,
  input logic              i_tvalid,
  input logic              i_tlast,
  input logic              o_tready,
  input logic [DATA_W-1:0] o_tdata,
  input logic              o_tvalid,
  input logic              o_tlast,
  input logic              i_tready
);

  // Beats already accepted in the current input packet
  int in_beats;
  // Failed assertions so far
  int fail_cnt = 0;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      in_beats <= 0;
    end else if (i_tvalid && o_tready) begin
      in_beats <= i_tlast ? 0 : in_beats + 1;
    end
  end

  out_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_tvalid && !i_tready |=> o_tvalid && $stable(o_tdata) && $stable(o_tlast))
    else begin
      $error("Output beat changed or vanished before it was accepted");
      fail_cnt = fail_cnt + 1;
    end

  reset_idle: assert property (@(posedge clk) !i_rst_n |=> !o_tvalid)
    else begin
      $error("o_tvalid is high right after reset");
      fail_cnt = fail_cnt + 1;
    end

  // Longer packets could never commit in the FIFO
  pkt_fits: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_tvalid && o_tready |-> in_beats < FIFO_DEPTH - 1)
    else begin
      $error("Input packet is longer than the FIFO can hold");
      fail_cnt = fail_cnt + 1;
    end

endmodule

bind pkt_filter_top pkt_filter_sva #(
  .DATA_W     (DATA_W),
  .FIFO_DEPTH (FIFO_DEPTH)
) pkt_filter_sva_i (
  .clk      (clk),
  .i_rst_n  (i_rst_n),
  .i_tvalid (i_tvalid),
  .i_tlast  (i_tlast),
  .o_tready (o_tready),
  .o_tdata  (o_tdata),
  .o_tvalid (o_tvalid),
  .o_tlast  (o_tlast),
  .i_tready (i_tready)
);

/* design/pkt_filter_top.sv */
// Packet filter top level

`timescale 1ns/1ps

module pkt_filter_top #(
  parameter int DATA_W     = 32,
  parameter int FIFO_DEPTH = 64
) (
  input  logic              clk,
  input  logic              i_rst_n,
  // Input stream
  input  logic [DATA_W-1:0] i_tdata,
  input  logic              i_tvalid,
  input  logic              i_tlast,
  input  logic              i_terror,
  output logic              o_tready,
  // Output stream
  output logic [DATA_W-1:0] o_tdata,
  output logic              o_tvalid,
  output logic              o_tlast,
  input  logic              i_tready,
  // APB
  input  logic              i_psel,
  input  logic              i_penable,
  input  logic              i_pwrite,
  input  logic [7:0]        i_paddr,
  input  logic [31:0]       i_pwdata,
  output logic [31:0]       o_prdata
);

  logic [pkt_filter_pkg::LEN_W-1:0] min_len;
  logic [pkt_filter_pkg::LEN_W-1:0] max_len;
  logic                             clear;
  logic                             pkt_commit;
  logic                             pkt_drop;
  logic                             drop;

  // FIFO to output stage
  logic [DATA_W-1:0] fifo_tdata;
  logic              fifo_tvalid;
  logic              fifo_tlast;
  logic              fifo_tready;

  pkt_filter_regs pkt_filter_regs_i (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_psel       (i_psel),
    .i_penable    (i_penable),
    .i_pwrite     (i_pwrite),
    .i_paddr      (i_paddr),
    .i_pwdata     (i_pwdata),
    .o_prdata     (o_prdata),
    .o_min_len    (min_len),
    .o_max_len    (max_len),
    .o_clear      (clear),
    .i_pkt_commit (pkt_commit),
    .i_pkt_drop   (pkt_drop)
  );

  pkt_length_check pkt_length_check_i (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_clear   (clear),
    .i_min_len (min_len),
    .i_max_len (max_len),
    .i_tvalid  (i_tvalid),
    .i_tlast   (i_tlast),
    .i_terror  (i_terror),
    .i_tready  (o_tready),
    .o_drop    (drop)
  );

  drop_packet_fifo #(
    .DATA_W     (DATA_W),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) drop_packet_fifo_i (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_clear      (clear),
    .i_tdata      (i_tdata),
    .i_tvalid     (i_tvalid),
    .i_tlast      (i_tlast),
    .i_drop       (drop),
    .o_tready     (o_tready),
    .o_tdata      (fifo_tdata),
    .o_tvalid     (fifo_tvalid),
    .o_tlast      (fifo_tlast),
    .i_tready     (fifo_tready),
    .o_pkt_commit (pkt_commit),
    .o_pkt_drop   (pkt_drop)
  );

  stream_out_reg #(
    .DATA_W (DATA_W)
  ) stream_out_reg_i (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_clear  (clear),
    .i_tdata  (fifo_tdata),
    .i_tlast  (fifo_tlast),
    .i_tvalid (fifo_tvalid),
    .o_tready (fifo_tready),
    .o_tdata  (o_tdata),
    .o_tlast  (o_tlast),
    .o_tvalid (o_tvalid),
    .i_tready (i_tready)
  );

endmodule

/* design/pkt_filter_regs.sv */
// Packet filter APB registers

`timescale 1ns/1ps

module pkt_filter_regs (
  input  logic                             clk,
  input  logic                             i_rst_n,
  // APB slave, no wait states
  input  logic                             i_psel,
  input  logic                             i_penable,
  input  logic                             i_pwrite,
  input  logic [7:0]                       i_paddr,
  input  logic [31:0]                      i_pwdata,
  output logic [31:0]                      o_prdata,
  // Control to the data path
  output logic [pkt_filter_pkg::LEN_W-1:0] o_min_len,
  output logic [pkt_filter_pkg::LEN_W-1:0] o_max_len,
  output logic                             o_clear,
  // Status from the FIFO
  input  logic                             i_pkt_commit,
  input  logic                             i_pkt_drop
);

  localparam int LW = pkt_filter_pkg::LEN_W;

  pkt_filter_pkg::reg_addr_e        addr;
  logic                             wr_en;
  logic [pkt_filter_pkg::CNT_W-1:0] good_cnt;
  logic [pkt_filter_pkg::CNT_W-1:0] drop_cnt;

  assign addr  = pkt_filter_pkg::reg_addr_e'(i_paddr);
  assign wr_en = i_psel & i_penable & i_pwrite;

  // Length limits
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_min_len <= pkt_filter_pkg::MIN_LEN_RST;
      o_max_len <= pkt_filter_pkg::MAX_LEN_RST;
    end else if (wr_en) begin
      case (addr)
        pkt_filter_pkg::MIN_LEN: o_min_len <= i_pwdata[LW-1:0];
        pkt_filter_pkg::MAX_LEN: o_max_len <= i_pwdata[LW-1:0];
        default: ;
      endcase
    end
  end

  // One-cycle clear from CTRL bit 0
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_clear <= 1'b0;
    end else begin
      o_clear <= wr_en && (addr == pkt_filter_pkg::CTRL) && i_pwdata[0];
    end
  end

  // Packet counters, free running and wrapping
  always_ff @(posedge clk) begin
    if (!i_rst_n || o_clear) begin
      good_cnt <= '0;
      drop_cnt <= '0;
    end else begin
      if (i_pkt_commit) begin
        good_cnt <= good_cnt + 1'b1;
      end
      if (i_pkt_drop) begin
        drop_cnt <= drop_cnt + 1'b1;
      end
    end
  end

  // Read mux, CTRL and unknown addresses read zero
  always_comb begin
    o_prdata = '0;
    if (i_psel && !i_pwrite) begin
      case (addr)
        pkt_filter_pkg::MIN_LEN:  o_prdata = {{(32-LW){1'b0}}, o_min_len};
        pkt_filter_pkg::MAX_LEN:  o_prdata = {{(32-LW){1'b0}}, o_max_len};
        pkt_filter_pkg::GOOD_CNT: o_prdata = good_cnt;
        pkt_filter_pkg::DROP_CNT: o_prdata = drop_cnt;
        default:                  o_prdata = '0;
      endcase
    end
  end

endmodule

/* design/stream_out_reg.sv */
// Two-entry stream output register

`timescale 1ns/1ps

module stream_out_reg #(
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              i_rst_n,
  input  logic              i_clear,
  input  logic [DATA_W-1:0] i_tdata,
  input  logic              i_tlast,
  input  logic              i_tvalid,
  output logic              o_tready,
  output logic [DATA_W-1:0] o_tdata,
  output logic              o_tlast,
  output logic              o_tvalid,
  input  logic              i_tready
);

  // Skid entry, occupied whenever o_tready is low
  logic [DATA_W-1:0] skid_data;
  logic              skid_last;

  logic load_main_in;
  logic load_skid;
  logic load_main_skid;

  assign load_main_in   = o_tready & (~o_tvalid | i_tready);
  assign load_skid      = o_tready & o_tvalid & ~i_tready & i_tvalid;
  assign load_main_skid = ~o_tready & i_tready;

  always_ff @(posedge clk) begin
    if (!i_rst_n || i_clear) begin
      o_tvalid <= 1'b0;
      o_tready <= 1'b1;
    end else if (load_main_in) begin
      o_tvalid <= i_tvalid;
    end else if (load_skid) begin
      o_tready <= 1'b0;
    end else if (load_main_skid) begin
      // Main stays valid with the skid contents
      o_tready <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load_main_in) begin
      o_tdata <= i_tdata;
      o_tlast <= i_tlast;
    end else if (load_main_skid) begin
      o_tdata <= skid_data;
      o_tlast <= skid_last;
    end
    if (load_skid) begin
      skid_data <= i_tdata;
      skid_last <= i_tlast;
    end
  end

endmodule

/* design/drop_packet_fifo.sv */
// Packet FIFO with drop on rewind

`timescale 1ns/1ps

module drop_packet_fifo #(
  parameter int DATA_W     = 32,
  parameter int FIFO_DEPTH = 64
) (
  input  logic              clk,
  input  logic              i_rst_n,
  input  logic              i_clear,
  // Input stream
  input  logic [DATA_W-1:0] i_tdata,
  input  logic              i_tvalid,
  input  logic              i_tlast,
  input  logic              i_drop,
  output logic              o_tready,
  // Output stream
  output logic [DATA_W-1:0] o_tdata,
  output logic              o_tvalid,
  output logic              o_tlast,
  input  logic              i_tready,
  // Packet status pulses
  output logic              o_pkt_commit,
  output logic              o_pkt_drop
);

  localparam int AW = $clog2(FIFO_DEPTH);

  // Each word keeps last above the data
  logic [DATA_W:0] mem [FIFO_DEPTH];

  // Pointers carry one extra wrap bit
  logic [AW:0]     wr_ptr;
  logic [AW:0]     start_ptr;
  logic [AW:0]     rd_ptr;

  // Packets committed by the writer and released by the reader
  logic [AW:0]     in_pkt_cnt;
  logic [AW:0]     out_pkt_cnt;

  logic            full;
  logic            empty;
  logic            hold;
  logic            wr_en;
  logic            rd_en;
  logic [DATA_W:0] rd_word;

  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign empty = (wr_ptr == rd_ptr);

  // Nothing leaves until a whole good packet sits in memory
  assign hold  = (in_pkt_cnt == out_pkt_cnt);

  assign o_tready = ~full;
  assign wr_en    = i_tvalid & ~full;
  assign rd_en    = ~empty & ~hold & i_tready;
  assign rd_word  = mem[rd_ptr[AW-1:0]];

  assign o_pkt_commit = wr_en & i_tlast & ~i_drop;
  assign o_pkt_drop   = wr_en & i_tlast & i_drop;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr[AW-1:0]] <= {i_tlast, i_tdata};
    end
  end

  // Write side
  always_ff @(posedge clk) begin
    if (!i_rst_n || i_clear) begin
      wr_ptr     <= '0;
      start_ptr  <= '0;
      in_pkt_cnt <= '0;
    end else if (wr_en) begin
      if (i_tlast && i_drop) begin
        // Bad packet, back to where it began
        wr_ptr <= start_ptr;
      end else if (i_tlast) begin
        wr_ptr     <= wr_ptr + 1'b1;
        start_ptr  <= wr_ptr + 1'b1;
        in_pkt_cnt <= in_pkt_cnt + 1'b1;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  // Read side
  always_ff @(posedge clk) begin
    if (!i_rst_n || i_clear) begin
      rd_ptr      <= '0;
      out_pkt_cnt <= '0;
      o_tvalid    <= 1'b0;
    end else begin
      if (i_tready) begin
        o_tvalid <= ~empty & ~hold;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // A packet counts as released once its last word is read
      if (rd_en && rd_word[DATA_W]) begin
        out_pkt_cnt <= out_pkt_cnt + 1'b1;
      end
    end
  end

  // Registered memory read
  always_ff @(posedge clk) begin
    if (i_tready) begin
      o_tdata <= rd_word[DATA_W-1:0];
      o_tlast <= rd_word[DATA_W];
    end
  end

endmodule

/* design/pkt_length_check.sv */
// Packet length checker

`timescale 1ns/1ps

module pkt_length_check (
  input  logic                            clk,
  input  logic                            i_rst_n,
  input  logic                            i_clear,
  input  logic [pkt_filter_pkg::LEN_W-1:0] i_min_len,
  input  logic [pkt_filter_pkg::LEN_W-1:0] i_max_len,
  input  logic                            i_tvalid,
  input  logic                            i_tlast,
  input  logic                            i_terror,
  input  logic                            i_tready,
  output logic                            o_drop
);

  localparam int LW = pkt_filter_pkg::LEN_W;

  pkt_filter_pkg::chk_state_e state;
  logic [LW-1:0]              beat_cnt;
  logic [LW:0]                cur_len;
  logic                       beat;
  logic                       too_short;
  logic                       too_long;

  assign beat = i_tvalid & i_tready;

  // Length including the beat now on the bus
  assign cur_len = (state == pkt_filter_pkg::IN_PKT) ? {1'b0, beat_cnt} + 1'b1
                                                       : {{LW{1'b0}}, 1'b1};

  assign too_short = cur_len < {1'b0, i_min_len};
  assign too_long  = cur_len > {1'b0, i_max_len};

  // Decision only matters on the last beat
  assign o_drop = i_tvalid & i_tlast & (too_short | too_long | i_terror);

  always_ff @(posedge clk) begin
    if (!i_rst_n || i_clear) begin
      state    <= pkt_filter_pkg::IDLE;
      beat_cnt <= '0;
    end else if (beat) begin
      if (i_tlast) begin
        state    <= pkt_filter_pkg::IDLE;
        beat_cnt <= '0;
      end else begin
        state    <= pkt_filter_pkg::IN_PKT;
        beat_cnt <= cur_len[LW-1:0];
      end
    end
  end

endmodule

/* design/pkt_filter_pkg.sv */
// Packet filter shared definitions

package pkt_filter_pkg;

  // Width of packet lengths and length limits
  localparam int LEN_W = 16;

  // Width of the packet counters
  localparam int CNT_W = 32;

  // APB word addresses
  typedef enum logic [7:0] {
    CTRL     = 8'h00,
    MIN_LEN  = 8'h04,
    MAX_LEN  = 8'h08,
    GOOD_CNT = 8'h0C,
    DROP_CNT = 8'h10
  } reg_addr_e;

  // Length checker position within a packet
  typedef enum logic {
    IDLE,
    IN_PKT
  } chk_state_e;

  // Length limits after reset
  localparam logic [LEN_W-1:0] MIN_LEN_RST = 16'd1;
  localparam logic [LEN_W-1:0] MAX_LEN_RST = 16'hFFFF;

endpackage
